//--- vlog.f
+incdir+include
verilog/exu_pkg.sv
verilog/exu_stage_if.sv
verilog/exu_regfile.sv
verilog/exu_alu.sv
verilog/exu_issue_stage.sv
verilog/exu_execute_stage.sv
verilog/exu_writeback_stage.sv
verilog/exu_top.sv
test/exu_checker.sv
test/exu_tb.sv

//--- Bender.yml
package:
  name: exu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/exu_pkg.sv
      - verilog/exu_stage_if.sv
      - verilog/exu_regfile.sv
      - verilog/exu_alu.sv
      - verilog/exu_issue_stage.sv
      - verilog/exu_execute_stage.sv
      - verilog/exu_writeback_stage.sv
      - verilog/exu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/exu_checker.sv
      - test/exu_tb.sv

//--- test/exu_tb.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_tb;
    import exu_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_INSNS = 400;
    localparam int SEED = 46;
    // x0 to x5 only so dependencies are frequent
    localparam int REG_POOL = 6;

    // one expected result per accepted instruction
    typedef struct packed {
        op_t op;
        logic [`EXU_XLEN-1:0] pc;
        logic [`EXU_XLEN-1:0] next_pc;
        logic [`EXU_REG_ADDR_W-1:0] rd;
        logic wen;
        // branches carry no meaningful wdata
        logic has_value;
        logic [`EXU_XLEN-1:0] wdata;
    } expect_t;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    op_t in_op;
    logic [`EXU_REG_ADDR_W-1:0] in_rd;
    logic [`EXU_REG_ADDR_W-1:0] in_rs1;
    logic [`EXU_REG_ADDR_W-1:0] in_rs2;
    logic [`EXU_XLEN-1:0] in_imm;
    logic [`EXU_XLEN-1:0] in_pc;
    logic out_ready;
    logic out_valid;
    logic [`EXU_XLEN-1:0] out_pc;
    logic [`EXU_XLEN-1:0] out_next_pc;
    logic [`EXU_REG_ADDR_W-1:0] out_rd;
    logic out_wen;
    logic [`EXU_XLEN-1:0] out_wdata;

    // architectural state as seen in acceptance order
    logic [`EXU_XLEN-1:0] model_regs [`EXU_NUM_REGS];
    expect_t expected_q [$];
    int error_count = 0;
    int checked_count = 0;

    exu_top i_dut (
        .clk (clk), .reset (reset),
        .in_valid (in_valid), .in_ready (in_ready), .in_op (in_op),
        .in_rd (in_rd), .in_rs1 (in_rs1), .in_rs2 (in_rs2),
        .in_imm (in_imm), .in_pc (in_pc),
        .out_ready (out_ready), .out_valid (out_valid),
        .out_pc (out_pc), .out_next_pc (out_next_pc), .out_rd (out_rd),
        .out_wen (out_wen), .out_wdata (out_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // expected outcome straight from the instruction semantics
    function automatic expect_t exu_ref(op_t op, logic [`EXU_XLEN-1:0] rs1_val,
                                        logic [`EXU_XLEN-1:0] rs2_val,
                                        logic [`EXU_XLEN-1:0] imm,
                                        logic [`EXU_XLEN-1:0] pc,
                                        logic [`EXU_REG_ADDR_W-1:0] rd);
        expect_t e;
        logic [`EXU_XLEN-1:0] src2;
        logic taken;
        e.op = op;
        e.pc = pc;
        e.rd = rd;
        e.next_pc = pc + `EXU_INSN_BYTES;
        e.has_value = 1'b1;
        e.wdata = '0;
        taken = 1'b0;
        // immediate forms use imm in place of rs2
        src2 = (op inside {op_add, op_sub, op_and, op_or, op_xor,
                           op_sll, op_srl, op_sra, op_slt, op_sltu}) ? rs2_val : imm;
        case (op)
            op_add, op_addi: e.wdata = rs1_val + src2;
            op_sub: e.wdata = rs1_val - rs2_val;
            op_and, op_andi: e.wdata = rs1_val & src2;
            op_or, op_ori: e.wdata = rs1_val | src2;
            op_xor, op_xori: e.wdata = rs1_val ^ src2;
            op_sll, op_slli: e.wdata = rs1_val << src2[`EXU_SHAMT_W-1:0];
            op_srl, op_srli: e.wdata = rs1_val >> src2[`EXU_SHAMT_W-1:0];
            op_sra, op_srai: e.wdata = $signed(rs1_val) >>> src2[`EXU_SHAMT_W-1:0];
            op_slt, op_slti: e.wdata = ($signed(rs1_val) < $signed(src2)) ? 64'd1 : 64'd0;
            op_sltu, op_sltiu: e.wdata = (rs1_val < src2) ? 64'd1 : 64'd0;
            op_lui: e.wdata = imm;
            op_auipc: e.wdata = pc + imm;
            op_jal: begin
                e.wdata = pc + `EXU_INSN_BYTES;
                e.next_pc = pc + imm;
            end
            op_jalr: begin
                // target lsb always cleared
                e.wdata = pc + `EXU_INSN_BYTES;
                e.next_pc = (rs1_val + imm) & ~64'd1;
            end
            default: begin
                e.has_value = 1'b0;
                case (op)
                    op_beq: taken = (rs1_val == rs2_val);
                    op_bne: taken = (rs1_val != rs2_val);
                    op_blt: taken = ($signed(rs1_val) < $signed(rs2_val));
                    op_bge: taken = ($signed(rs1_val) >= $signed(rs2_val));
                    op_bltu: taken = (rs1_val < rs2_val);
                    op_bgeu: taken = (rs1_val >= rs2_val);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    e.next_pc = pc + imm;
                end
            end
        endcase
        // x0 target and branches never write
        e.wen = e.has_value && (rd != '0);
        return e;
    endfunction

    task automatic report_mismatch(string test_name, string field,
                                   logic [`EXU_XLEN-1:0] expected,
                                   logic [`EXU_XLEN-1:0] actual);
        $display("error: %s %s expected %h actual %h", test_name, field, expected, actual);
        error_count++;
    endtask

    // sources read from the model at the moment of acceptance
    task automatic record_acceptance();
        expect_t e;
        e = exu_ref(in_op, model_regs[in_rs1], model_regs[in_rs2], in_imm, in_pc, in_rd);
        expected_q.push_back(e);
        if (e.wen) begin
            model_regs[in_rd] = e.wdata;
        end
    endtask

    task automatic offer_random_insn();
        op_t op;
        logic [`EXU_XLEN-1:0] r;
        op = op_t'($urandom % 29);
        r = {$urandom, $urandom};
        in_op = op;
        in_rd = `EXU_REG_ADDR_W'($urandom % REG_POOL);
        in_rs1 = `EXU_REG_ADDR_W'($urandom % REG_POOL);
        in_rs2 = `EXU_REG_ADDR_W'($urandom % REG_POOL);
        // shift immediates stay within 0..63
        // other immediates are half 12-bit signed and half full width
        if (op inside {op_slli, op_srli, op_srai}) begin
            in_imm = {58'd0, r[5:0]};
        end else if (r[63]) begin
            in_imm = r;
        end else begin
            in_imm = {{52{r[11]}}, r[11:0]};
        end
        r = {$urandom, $urandom};
        in_pc = r & ~64'h3;
        in_valid = 1'b1;
    endtask

    // inputs change 1 ns after the rising edge
    initial begin : drive_stimulus
        int accepted_count;
        logic accepted;
        void'($urandom(SEED));
        accepted_count = 0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_op = op_add;
        in_rd = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_imm = '0;
        in_pc = '0;
        out_ready = 1'b0;
        for (int i = 0; i < `EXU_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        while (accepted_count < NUM_INSNS) begin
            // handshake sampled mid-cycle where it is settled
            @(negedge clk);
            accepted = in_valid && in_ready;
            if (accepted) begin
                record_acceptance();
                accepted_count++;
            end
            @(posedge clk);
            #1;
            out_ready = (($urandom % 10) < 7);
            // a pending offer holds until taken
            if (accepted || !in_valid) begin
                if (accepted_count < NUM_INSNS && ($urandom % 4) != 0) begin
                    offer_random_insn();
                end else begin
                    in_valid = 1'b0;
                end
            end
        end
        // drain under back-pressure
        while (checked_count < NUM_INSNS) begin
            @(posedge clk);
            #1 out_ready = (($urandom % 10) < 7);
        end
        // a few idle cycles to catch stray outputs
        out_ready = 1'b1;
        repeat (5) @(posedge clk);
        if (expected_q.size() != 0) begin
            $display("error: %0d accepted instructions never came out", expected_q.size());
            error_count++;
        end
        $display("checked %0d results, %0d errors", checked_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // one expected record per output transfer
    initial begin : compare_results
        expect_t want;
        string test_name;
        forever begin
            @(negedge clk);
            if (out_valid === 1'b1 && out_ready === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("error: a result came out with no instruction pending");
                    error_count++;
                end else begin
                    want = expected_q.pop_front();
                    test_name = $sformatf("insn %0d %s", checked_count, want.op.name());
                    if (out_pc !== want.pc) begin
                        report_mismatch(test_name, "pc", want.pc, out_pc);
                    end
                    if (out_next_pc !== want.next_pc) begin
                        report_mismatch(test_name, "next_pc", want.next_pc, out_next_pc);
                    end
                    if (out_rd !== want.rd) begin
                        report_mismatch(test_name, "rd", want.rd, out_rd);
                    end
                    if (out_wen !== want.wen) begin
                        report_mismatch(test_name, "wen", want.wen, out_wen);
                    end
                    if (want.has_value && out_wdata !== want.wdata) begin
                        report_mismatch(test_name, "wdata", want.wdata, out_wdata);
                    end
                end
                checked_count++;
            end
        end
    end

    // allows 20 cycles per instruction
    initial begin : watchdog
        #(NUM_INSNS * 20 * CLK_PERIOD);
        $display("error: timed out, the output stalled after %0d of %0d results",
                 checked_count, NUM_INSNS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- test/exu_checker.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_checker (
    input logic clk,
    input logic reset,
    input logic in_ready,
    input logic out_valid,
    input logic out_ready,
    input logic [`EXU_XLEN-1:0] out_pc,
    input logic [`EXU_XLEN-1:0] out_next_pc,
    input logic [`EXU_REG_ADDR_W-1:0] out_rd,
    input logic out_wen,
    input logic [`EXU_XLEN-1:0] out_wdata
);

    // stalled result holds until taken
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_pc) &&
            $stable(out_next_pc) && $stable(out_rd) && $stable(out_wen) && $stable(out_wdata))
        else $error("output changed while out_ready was low");

    // x0 is never a write target
    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_wen |-> out_rd != '0)
        else $error("write enable reported for register zero");

    // both handshakes idle right after reset
    assert property (@(posedge clk) reset |=> !out_valid && !in_ready)
        else $error("out_valid or in_ready high in the cycle after reset");

endmodule

bind exu_top exu_checker i_checker (
    .clk (clk), .reset (reset), .in_ready (in_ready),
    .out_valid (out_valid), .out_ready (out_ready),
    .out_pc (out_pc), .out_next_pc (out_next_pc), .out_rd (out_rd),
    .out_wen (out_wen), .out_wdata (out_wdata)
);

//--- verilog/exu_top.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_top (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  exu_pkg::op_t in_op,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rd,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rs1,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rs2,
    input  logic [`EXU_XLEN-1:0] in_imm,
    input  logic [`EXU_XLEN-1:0] in_pc,
    input  logic out_ready,
    output logic out_valid,
    output logic [`EXU_XLEN-1:0] out_pc,
    output logic [`EXU_XLEN-1:0] out_next_pc,
    output logic [`EXU_REG_ADDR_W-1:0] out_rd,
    output logic out_wen,
    output logic [`EXU_XLEN-1:0] out_wdata
);

    // writeback path back into the issue stage
    logic wr_en;
    logic [`EXU_REG_ADDR_W-1:0] wr_addr;
    logic [`EXU_XLEN-1:0] wr_data;

    exu_issue_if issue_if ();
    exu_result_if result_if ();

    exu_issue_stage i_issue (
        .clk (clk), .reset (reset),
        .in_valid (in_valid), .in_ready (in_ready), .in_op (in_op),
        .in_rd (in_rd), .in_rs1 (in_rs1), .in_rs2 (in_rs2),
        .in_imm (in_imm), .in_pc (in_pc),
        .issue (issue_if.source),
        .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data)
    );

    exu_execute_stage i_execute (
        .clk (clk), .reset (reset),
        .issue (issue_if.sink),
        .result (result_if.source)
    );

    exu_writeback_stage i_writeback (
        .clk (clk), .reset (reset),
        .result (result_if.sink),
        .out_valid (out_valid), .out_ready (out_ready),
        .out_pc (out_pc), .out_next_pc (out_next_pc), .out_wdata (out_wdata),
        .out_rd (out_rd), .out_wen (out_wen),
        .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data)
    );

endmodule

//--- verilog/exu_writeback_stage.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_writeback_stage (
    input  logic clk,
    input  logic reset,
    exu_result_if.sink result,
    output logic out_valid,
    input  logic out_ready,
    output logic [`EXU_XLEN-1:0] out_pc,
    output logic [`EXU_XLEN-1:0] out_next_pc,
    output logic [`EXU_XLEN-1:0] out_wdata,
    output logic [`EXU_REG_ADDR_W-1:0] out_rd,
    output logic out_wen,
    output logic wr_en,
    output logic [`EXU_REG_ADDR_W-1:0] wr_addr,
    output logic [`EXU_XLEN-1:0] wr_data
);

    logic load;

    // output register refills as it drains
    assign result.ready = !out_valid || out_ready;
    assign load = result.valid && result.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_wen <= 1'b0;
        end else begin
            if (result.ready) begin
                out_valid <= result.valid;
            end
            if (load) begin
                out_wen <= result.wen;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_pc <= result.pc;
            out_next_pc <= result.next_pc;
            out_rd <= result.rd;
            out_wdata <= result.wdata;
        end
    end

    // commit to regfile and scoreboard on the reported transfer
    assign wr_en = out_valid && out_ready && out_wen;
    assign wr_addr = out_rd;
    assign wr_data = out_wdata;

endmodule

//--- verilog/exu_execute_stage.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_execute_stage (
    input  logic clk,
    input  logic reset,
    exu_issue_if.sink issue,
    exu_result_if.source result
);
    import exu_pkg::*;

    logic [`EXU_XLEN-1:0] alu_result;
    logic [`EXU_XLEN-1:0] seq_pc;
    logic [`EXU_XLEN-1:0] target_pc;
    logic [`EXU_XLEN-1:0] next_pc;
    logic [`EXU_XLEN-1:0] wdata;
    logic taken;
    logic accept;

    exu_alu i_alu (
        .mode      (issue.alu_mode),
        .operand_a (issue.operand_a),
        .operand_b (issue.operand_b),
        .result    (alu_result)
    );

    // fall-through and pc-relative target
    assign seq_pc = issue.pc + `EXU_INSN_BYTES;
    assign target_pc = issue.pc + issue.imm;

    // compare modes yield 0 or 1, bit 0 is the whole answer
    always_comb begin
        case (issue.op)
            op_beq: taken = (alu_result == '0);
            op_bne: taken = (alu_result != '0);
            op_blt, op_bltu: taken = alu_result[0];
            op_bge, op_bgeu: taken = !alu_result[0];
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = seq_pc;
        wdata = alu_result;
        case (issue.op)
            op_jal: begin
                next_pc = target_pc;
                wdata = seq_pc;
            end
            op_jalr: begin
                // rs1 + imm with lsb forced low
                next_pc = {alu_result[`EXU_XLEN-1:1], 1'b0};
                wdata = seq_pc;
            end
            default: begin
                if (taken) begin
                    next_pc = target_pc;
                end
            end
        endcase
    end

    // take a new item when empty or when ours leaves
    assign issue.ready = !result.valid || result.ready;
    assign accept = issue.valid && issue.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (issue.ready) begin
            result.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result.pc <= issue.pc;
            result.next_pc <= next_pc;
            result.rd <= issue.rd;
            result.wen <= issue.wen;
            result.wdata <= wdata;
        end
    end

endmodule

//--- verilog/exu_issue_stage.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_issue_stage (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  exu_pkg::op_t in_op,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rd,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rs1,
    input  logic [`EXU_REG_ADDR_W-1:0] in_rs2,
    input  logic [`EXU_XLEN-1:0] in_imm,
    input  logic [`EXU_XLEN-1:0] in_pc,
    exu_issue_if.source issue,
    input  logic wr_en,
    input  logic [`EXU_REG_ADDR_W-1:0] wr_addr,
    input  logic [`EXU_XLEN-1:0] wr_data
);
    import exu_pkg::*;

    // one pending-write bit per register
    logic [`EXU_NUM_REGS-1:0] busy;
    // held low for one cycle after reset
    logic issue_en;
    logic [`EXU_XLEN-1:0] rs1_data;
    logic [`EXU_XLEN-1:0] rs2_data;
    logic [`EXU_XLEN-1:0] op_a;
    logic [`EXU_XLEN-1:0] op_b;
    alu_mode_t mode;
    logic in_wen;
    logic hazard;
    logic accept;

    exu_regfile i_regfile (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (in_rs1),
        .rd_addr_b (in_rs2),
        .rd_data_a (rs1_data),
        .rd_data_b (rs2_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    // branches never write, x0 target dropped
    assign in_wen = !(in_op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu}) &&
                    (in_rd != '0);

    // raw on either source, waw on a pending rd
    assign hazard = (in_rs1 != '0 && busy[in_rs1]) ||
                    (in_rs2 != '0 && busy[in_rs2]) ||
                    (in_wen && busy[in_rd]);

    // slot free when empty or draining this cycle
    assign in_ready = issue_en && !hazard && (!issue.valid || issue.ready);
    assign accept = in_valid && in_ready;

    always_comb begin
        // operand a
        case (in_op)
            op_auipc, op_jal: op_a = in_pc;
            op_lui: op_a = '0;
            default: op_a = rs1_data;
        endcase
        // operand b, rs2 for register forms and branches
        case (in_op)
            op_add, op_sub, op_and, op_or, op_xor,
            op_sll, op_srl, op_sra, op_slt, op_sltu,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: op_b = rs2_data;
            default: op_b = in_imm;
        endcase
        // alu mode, branches reuse sub and compares
        case (in_op)
            op_sub, op_beq, op_bne: mode = alu_sub;
            op_and, op_andi: mode = alu_and;
            op_or, op_ori: mode = alu_or;
            op_xor, op_xori: mode = alu_xor;
            op_sll, op_slli: mode = alu_sll;
            op_srl, op_srli: mode = alu_srl;
            op_sra, op_srai: mode = alu_sra;
            op_slt, op_slti, op_blt, op_bge: mode = alu_slt;
            op_sltu, op_sltiu, op_bltu, op_bgeu: mode = alu_sltu;
            default: mode = alu_add;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_en <= 1'b0;
            busy <= '0;
            issue.valid <= 1'b0;
        end else begin
            issue_en <= 1'b1;
            if (!issue.valid || issue.ready) begin
                issue.valid <= accept;
            end
            // release on retire, new claim wins on same register
            if (wr_en) begin
                busy[wr_addr] <= 1'b0;
            end
            if (accept && in_wen) begin
                busy[in_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue.op <= in_op;
            issue.rd <= in_rd;
            issue.wen <= in_wen;
            issue.operand_a <= op_a;
            issue.operand_b <= op_b;
            issue.alu_mode <= mode;
            issue.pc <= in_pc;
            issue.imm <= in_imm;
        end
    end

endmodule

//--- verilog/exu_alu.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_alu (
    input  exu_pkg::alu_mode_t mode,
    input  logic [`EXU_XLEN-1:0] operand_a,
    input  logic [`EXU_XLEN-1:0] operand_b,
    output logic [`EXU_XLEN-1:0] result
);
    import exu_pkg::*;

    // shift amount from low bits of b only
    logic [`EXU_SHAMT_W-1:0] shamt;
    logic lt_signed;
    logic lt_unsigned;

    assign shamt = operand_b[`EXU_SHAMT_W-1:0];
    assign lt_signed = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (mode)
            alu_add: result = operand_a + operand_b;
            alu_sub: result = operand_a - operand_b;
            alu_and: result = operand_a & operand_b;
            alu_or: result = operand_a | operand_b;
            alu_xor: result = operand_a ^ operand_b;
            alu_sll: result = operand_a << shamt;
            alu_srl: result = operand_a >> shamt;
            // arithmetic, sign bit replicated
            alu_sra: result = $signed(operand_a) >>> shamt;
            // compares zero-extend a single bit
            alu_slt: result = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
            default: result = '0;
        endcase
    end

endmodule

//--- verilog/exu_regfile.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_regfile (
    input  logic clk,
    input  logic reset,
    input  logic [`EXU_REG_ADDR_W-1:0] rd_addr_a,
    input  logic [`EXU_REG_ADDR_W-1:0] rd_addr_b,
    output logic [`EXU_XLEN-1:0] rd_data_a,
    output logic [`EXU_XLEN-1:0] rd_data_b,
    input  logic wr_en,
    input  logic [`EXU_REG_ADDR_W-1:0] wr_addr,
    input  logic [`EXU_XLEN-1:0] wr_data
);

    logic [`EXU_XLEN-1:0] regs [`EXU_NUM_REGS];

    // cleared on reset, x0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `EXU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 reads zero
    // same-cycle write passes straight through to the reader
    assign rd_data_a = (rd_addr_a == '0) ? '0 :
                       (wr_en && wr_addr == rd_addr_a) ? wr_data :
                       regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 :
                       (wr_en && wr_addr == rd_addr_b) ? wr_data :
                       regs[rd_addr_b];

endmodule

//--- verilog/exu_stage_if.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

// issue stage to execute stage
interface exu_issue_if;
    import exu_pkg::*;

    logic valid;
    logic ready;
    op_t op;
    logic [`EXU_REG_ADDR_W-1:0] rd;
    logic wen;
    logic [`EXU_XLEN-1:0] operand_a;
    logic [`EXU_XLEN-1:0] operand_b;
    alu_mode_t alu_mode;
    // pc and imm kept for target and link computation
    logic [`EXU_XLEN-1:0] pc;
    logic [`EXU_XLEN-1:0] imm;

    modport source (output valid, op, rd, wen, operand_a, operand_b, alu_mode, pc, imm,
                    input ready);
    modport sink (input valid, op, rd, wen, operand_a, operand_b, alu_mode, pc, imm,
                  output ready);
endinterface

// execute stage to writeback stage
interface exu_result_if;
    logic valid;
    logic ready;
    logic [`EXU_XLEN-1:0] pc;
    // resolved next pc
    logic [`EXU_XLEN-1:0] next_pc;
    logic [`EXU_REG_ADDR_W-1:0] rd;
    logic wen;
    logic [`EXU_XLEN-1:0] wdata;

    modport source (output valid, pc, next_pc, rd, wen, wdata, input ready);
    modport sink (input valid, pc, next_pc, rd, wen, wdata, output ready);
endinterface

//--- verilog/exu_pkg.sv
`include "exu_consts.svh"

package exu_pkg;

    // decoded instruction, one entry per supported operation
    typedef enum logic [`EXU_OP_W-1:0] {
        // register-register alu
        op_add, op_sub, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_slt, op_sltu,
        // register-immediate alu
        op_addi, op_andi, op_ori, op_xori,
        op_slli, op_srli, op_srai, op_slti, op_sltiu,
        // upper immediates
        op_lui, op_auipc,
        // jumps
        op_jal, op_jalr,
        // conditional branches
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu
    } op_t;

    // alu function select
    typedef enum logic [`EXU_ALU_MODE_W-1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        // signed compare, result 0 or 1
        alu_slt,
        // unsigned compare
        alu_sltu
    } alu_mode_t;

endpackage

//--- include/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// datapath and pc width
`define EXU_XLEN 64

// general register file
`define EXU_NUM_REGS 32
`define EXU_REG_ADDR_W 5

// shift amount taken from low bits of operand b
`define EXU_SHAMT_W 6

// sequential pc step
`define EXU_INSN_BYTES 4

// encoded widths of opcode and alu mode
`define EXU_OP_W 5
`define EXU_ALU_MODE_W 4

`endif
